// ==== trig_pipe.f ====
src/trig_pipe_pkg.sv
src/pipe_start_fsm.sv
src/pipe_buffer.sv
src/pipe_out_stage.sv
src/trig_pipe_top.sv
testbench/trig_pipe_chk.sv
testbench/trig_pipe_tb.sv

// ==== Bender.yml ====
package:
  name: trig_pipe

sources:
  - target: rtl
    files:
      - src/trig_pipe_pkg.sv
      - src/pipe_start_fsm.sv
      - src/pipe_buffer.sv
      - src/pipe_out_stage.sv
      - src/trig_pipe_top.sv

  - target: test
    files:
      - testbench/trig_pipe_chk.sv
      - testbench/trig_pipe_tb.sv

// ==== testbench/trig_pipe_vectors.txt ====
# id kind mask(hex) pdepth sel_tpls inj_pattern(hex) run_cycles
# kind 0 no restart, 1 jrestart, 2 csp_restart, 3 restartp with mask
# inj_pattern bit (edge mod 32) gives inj_pulse at that edge
1  0 0 8   0 00000000 10
2  1 0 8   0 00000000 40
3  0 0 8   0 00000000 20
4  3 2 5   0 00000000 30
5  0 0 5   0 00000000 20
6  1 0 12  1 a5c30f1e 40
7  0 0 12  1 ffff0000 25
8  0 0 3   1 13579bdf 30
9  2 0 3   0 00000000 40
10 0 0 17  0 00000000 20
11 3 1 20  1 0f0f0f0f 50
12 3 3 6   1 80000001 35
13 2 0 1   0 00000000 20
14 1 0 100 0 00000000 130
15 3 2 2   1 deadbeef 25

// ==== testbench/trig_pipe_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module trig_pipe_tb;

	import trig_pipe_pkg::*;

	localparam int SEGS    = 2;
	localparam int MAX_TST = 64;                    // Vector lines kept
	localparam int HIST    = 4096;                  // Ring of driven words
	localparam int RST_CYC = 4;
	localparam int MARGIN  = 100;

	logic               CLK160;
	logic               trst;
	logic               jrestart;
	logic               csp_restart;
	logic [SEGS-1:0]    restartp;
	depth_t             pdepth;
	tp_ctl_t            tp;
	sample_t [SEGS-1:0] din;
	wire sample_t [SEGS-1:0] pip_out;
	wire [SEGS-1:0]          out_valid;
	wire depth_t [SEGS-1:0]  occupancy;

	int          t_id [MAX_TST];
	int          t_kind [MAX_TST];                  // 0 none 1 joint 2 debug 3 mask
	logic [31:0] t_mask [MAX_TST];
	int          t_depth [MAX_TST];
	int          t_sel [MAX_TST];
	logic [31:0] t_inj [MAX_TST];                   // Bit n%32 drives inj_pulse
	int          t_len [MAX_TST];
	int          n_tests;

	sample_t hist [SEGS][HIST];                     // Expected written words by edge
	int      cur_r [SEGS];                          // Edge that sampled the restart
	int      cur_d [SEGS];
	bit      cur_on [SEGS];
	int      prev_r [SEGS];
	int      prev_d [SEGS];
	bit      prev_on [SEGS];

	int seed = 32'hbae5e36d;
	int cyc = 0;                                    // Rising edges so far
	int limit = 0;
	int err_cnt;
	int pass_cnt = 0;
	int fail_cnt = 0;

	trig_pipe_top #(.SEGS(SEGS)) dut0 (
		.CLK160(CLK160), .trst(trst), .jrestart(jrestart), .csp_restart(csp_restart),
		.restartp(restartp), .pdepth(pdepth), .tp(tp), .din(din),
		.pip_out(pip_out), .out_valid(out_valid), .occupancy(occupancy)
	);

	initial begin
		CLK160 = 1'b0;
		forever #10 CLK160 = ~CLK160;               // 50 MHz model of CLK160
	end

	always @(posedge CLK160) begin
		cyc <= cyc + 1;
		if (limit > 0 && cyc >= limit) begin
			$display("run stopped at cycle %0d, the tests did not finish in time", cyc);
			$display("Test FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Vector file
	////////////////////////////////////////////////////////////

	task automatic read_vectors(output bit ok);
		int          fd;
		int          cnt;
		int          id, kind, depth, sel, len;
		logic [31:0] mask, inj;
		string       line;
		int          sum;
		fd = $fopen("testbench/trig_pipe_vectors.txt", "r");
		n_tests = 0;
		sum = 0;
		ok = 1'b0;
		if (fd != 0) begin
			while (!$feof(fd) && n_tests < MAX_TST) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					cnt = $sscanf(line, "%d %d %h %d %d %h %d",
						id, kind, mask, depth, sel, inj, len);
					if (cnt == 7) begin
						t_id[n_tests]    = id;
						t_kind[n_tests]  = kind;
						t_mask[n_tests]  = mask;
						t_depth[n_tests] = depth;
						t_sel[n_tests]   = sel;
						t_inj[n_tests]   = inj;
						t_len[n_tests]   = len;
						sum += len + depth;
						n_tests++;
					end
				end
			end
			$fclose(fd);
			ok = (n_tests > 0);
		end
		limit = sum + MARGIN + RST_CYC + 2;         // Runs plus latencies plus slack
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and delay model
	////////////////////////////////////////////////////////////

	task automatic drive_cycle(input int k, input int step);
		int s;
		int n;
		bit hit;
		sample_t w;
		n = cyc + 1;                                // Edge that samples these values
		jrestart     = 1'b0;
		csp_restart  = 1'b0;
		restartp     = '0;
		pdepth       = depth_t'(t_depth[k]);
		tp.sel_tpls  = (t_sel[k] != 0);
		tp.inj_pulse = t_inj[k][n % 32];
		for (s = 0; s < SEGS; s++) begin
			hit = (t_kind[k] == 1) || (t_kind[k] == 2) || (t_kind[k] == 3 && t_mask[k][s]);
			if (step == 0 && hit) begin
				prev_on[s] = cur_on[s];             // Old stream lasts to edge n+1
				prev_r[s]  = cur_r[s];
				prev_d[s]  = cur_d[s];
				cur_on[s]  = 1'b1;
				cur_r[s]   = n;
				cur_d[s]   = t_depth[k];
			end
			din[s] = $random(seed);
			w = din[s];
			if (tp.sel_tpls)
				w[0] = tp.inj_pulse;                // Pulse value lands in bit 0
			hist[s][n % HIST] = w;
		end
		if (step == 0) begin
			case (t_kind[k])
				1: jrestart = 1'b1;
				2: csp_restart = 1'b1;
				3: restartp = t_mask[k][SEGS-1:0];
				default: ;
			endcase
		end
	endtask

	task automatic report_mismatch(input int tid, input int s, input string sig,
		input logic [31:0] exp, input logic [31:0] act);
		$display("mismatch test %0d cycle %0d seg %0d %s expected %h actual %h",
			tid, cyc, s, sig, exp, act);
		err_cnt++;
	endtask

	task automatic check_seg(input int s, input int tid);
		int      n;
		int      r;
		int      d;
		int      fill;
		bit      on;
		logic    exp_v;
		depth_t  exp_occ;
		sample_t exp_out;
		n = cyc;
		on = prev_on[s];
		r = prev_r[s];
		d = prev_d[s];
		if (cur_on[s] && n >= cur_r[s] + 2) begin
			on = 1'b1;                              // New sequence has cleared the stage
			r  = cur_r[s];
			d  = cur_d[s];
		end
		exp_v   = 1'b0;
		exp_occ = '0;
		exp_out = '0;
		if (on) begin
			fill    = n - r - 2;
			exp_occ = depth_t'(fill < d ? fill : d);
			if (n >= r + d + 4) begin
				exp_v   = 1'b1;
				exp_out = hist[s][(n - d - 2) % HIST];  // Latency pdepth + 2
			end
		end
		if (out_valid[s] !== exp_v)
			report_mismatch(tid, s, "out_valid", 32'(exp_v), 32'(out_valid[s]));
		if (occupancy[s] !== exp_occ)
			report_mismatch(tid, s, "occupancy", 32'(exp_occ), 32'(occupancy[s]));
		if (pip_out[s] !== exp_out)
			report_mismatch(tid, s, "pip_out", exp_out, pip_out[s]);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int k;
		int i;
		int s;
		bit ok;
		trst        = 1'b0;
		jrestart    = 1'b0;
		csp_restart = 1'b0;
		restartp    = '0;
		pdepth      = '0;
		tp          = '0;
		din         = '0;
		for (s = 0; s < SEGS; s++) begin
			cur_on[s]  = 1'b0;
			prev_on[s] = 1'b0;
		end
		read_vectors(ok);
		if (!ok) begin
			$display("no usable test lines in testbench/trig_pipe_vectors.txt");
			$display("Test FAILED");
		end else begin
			#2 trst = 1'b1;                         // Clean edge for the async reset
			repeat (RST_CYC) @(posedge CLK160);
			@(negedge CLK160);
			trst = 1'b0;
			for (k = 0; k < n_tests; k++) begin
				err_cnt = 0;
				for (i = 0; i < t_len[k]; i++) begin
					@(negedge CLK160);
					for (s = 0; s < SEGS; s++)
						check_seg(s, t_id[k]);
					drive_cycle(k, i);
				end
				if (err_cnt == 0)
					pass_cnt++;
				else
					fail_cnt++;
				$display("test %0d kind %0d depth %0d: %0d cycles, %0d errors",
					t_id[k], t_kind[k], t_depth[k], t_len[k], err_cnt);
			end
			$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
			if (fail_cnt == 0)
				$display("Test OK");
			else
				$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/trig_pipe_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module trig_pipe_chk (
	input wire                           CLK160,
	input wire                           trst,
	input wire trig_pipe_pkg::pipe_ctl_t ctl
);

	////////////////////////////////////////////////////////////
	// Start sequence control rules
	////////////////////////////////////////////////////////////

	// Pointer clear is a single strobe
	a_reset_one_cycle: assert property (@(posedge CLK160) disable iff (trst)
		ctl.pipe_reset |=> !ctl.pipe_reset)
		else $error("pipe_reset stayed high for more than one cycle");

	// Reads only while writing
	a_rena_needs_wena: assert property (@(posedge CLK160) disable iff (trst)
		ctl.rena |-> ctl.wena)
		else $error("rena high while wena low");

	// Fill always follows the pipeline reset
	a_fill_after_reset: assert property (@(posedge CLK160) disable iff (trst)
		ctl.pipe_reset |=> (ctl.wena && !ctl.rena))
		else $error("no fill cycle after pipe_reset");

	a_quiet_in_reset: assert property (@(posedge CLK160)
		trst |-> (ctl == '0))
		else $error("control outputs active during trst");

endmodule

// One checker per segment FSM
bind pipe_start_fsm trig_pipe_chk u_chk (
	.CLK160 (CLK160),
	.trst   (trst),
	.ctl    (ctl)
);

`default_nettype wire

// ==== src/trig_pipe_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module trig_pipe_top #(
	parameter int SEGS = 2                            // Segments in the group
) (
	input  wire                                    CLK160,
	input  wire                                    trst,
	input  wire                                    jrestart,     // Joint restart
	input  wire                                    csp_restart,  // Debug restart
	input  wire [SEGS-1:0]                         restartp,     // Per segment
	input  wire trig_pipe_pkg::depth_t             pdepth,
	input  wire trig_pipe_pkg::tp_ctl_t            tp,
	input  wire trig_pipe_pkg::sample_t [SEGS-1:0] din,
	output wire trig_pipe_pkg::sample_t [SEGS-1:0] pip_out,
	output wire [SEGS-1:0]                         out_valid,
	output wire trig_pipe_pkg::depth_t [SEGS-1:0]  occupancy
);

	import trig_pipe_pkg::*;

	wire [SEGS-1:0] seg_restart;          // Restart seen by each segment
	wire pipe_ctl_t ctl [SEGS];           // Decode stage outputs
	wire sample_t   rd_data [SEGS];       // Buffer read words

	// Shared sources reach every segment
	assign seg_restart = {SEGS{jrestart | csp_restart}} | restartp;

	////////////////////////////////////////////////////////////
	// Per segment pipeline
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < SEGS; g++) begin : seg
		pipe_start_fsm u_fsm (
			.CLK160  (CLK160),
			.trst    (trst),
			.restart (seg_restart[g]),
			.pdepth  (pdepth),
			.ctl     (ctl[g])
		);

		pipe_buffer u_buf (
			.CLK160  (CLK160),
			.trst    (trst),
			.ctl     (ctl[g]),
			.tp      (tp),                    // Same test pulse on all
			.din     (din[g]),
			.rd_data (rd_data[g])
		);

		pipe_out_stage u_out (
			.CLK160    (CLK160),
			.trst      (trst),
			.ctl       (ctl[g]),
			.rd_data   (rd_data[g]),
			.pip_out   (pip_out[g]),
			.out_valid (out_valid[g]),
			.occupancy (occupancy[g])
		);
	end

endmodule

`default_nettype wire

// ==== src/pipe_out_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_out_stage (
	input  wire                         CLK160,
	input  wire                         trst,
	input  wire trig_pipe_pkg::pipe_ctl_t ctl,
	input  wire trig_pipe_pkg::sample_t   rd_data,
	output trig_pipe_pkg::sample_t        pip_out,
	output logic                        out_valid,
	output trig_pipe_pkg::depth_t         occupancy
);

	import trig_pipe_pkg::*;

	logic rd_valid;                       // rd_data holds a fresh word

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			rd_valid  <= 1'b0;
			out_valid <= 1'b0;
			pip_out   <= '0;
		end else if (ctl.pipe_reset) begin
			rd_valid  <= 1'b0;                  // Drop stream on restart
			out_valid <= 1'b0;
			pip_out   <= '0;
		end else begin
			rd_valid  <= ctl.rena;              // Matches buffer read latency
			out_valid <= rd_valid;
			if (rd_valid)
				pip_out <= rd_data;             // Hold last word otherwise
		end
	end

	////////////////////////////////////////////////////////////
	// Occupancy
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst)
			occupancy <= '0;
		else if (ctl.pipe_reset)
			occupancy <= '0;
		else begin
			case ({ctl.rena, ctl.wena})
				2'b01:   occupancy <= occupancy + depth_t'(1);   // Fill
				2'b10:   occupancy <= occupancy - depth_t'(1);   // Drain
				default: occupancy <= occupancy;                 // Run or idle
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/pipe_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_buffer (
	input  wire                         CLK160,
	input  wire                         trst,
	input  wire trig_pipe_pkg::pipe_ctl_t ctl,
	input  wire trig_pipe_pkg::tp_ctl_t   tp,
	input  wire trig_pipe_pkg::sample_t   din,
	output trig_pipe_pkg::sample_t        rd_data
);

	import trig_pipe_pkg::*;

	sample_t mem [BUF_WORDS];             // Circular sample store
	sample_t wr_word;                     // din with test pulse applied
	sample_t din_q;                       // Input register
	depth_t  wr_ptr;                      // Next write address
	depth_t  rd_ptr;                      // Next read address

	// Test pulse takes over bit 0 only
	assign wr_word = {din[DATA_W-1:1], tp.sel_tpls ? tp.inj_pulse : din[0]};

	always_ff @(posedge CLK160) begin
		din_q <= wr_word;                   // Sample every cycle
	end

	////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (ctl.pipe_reset) begin
			wr_ptr <= '0;                       // Start of a new fill
			rd_ptr <= '0;
		end else begin
			if (ctl.wena)
				wr_ptr <= wr_ptr + depth_t'(1); // Wraps at BUF_WORDS
			if (ctl.rena)
				rd_ptr <= rd_ptr + depth_t'(1);
		end
	end

	// Memory with registered read port
	always_ff @(posedge CLK160) begin
		if (ctl.wena)
			mem[wr_ptr] <= din_q;
		if (ctl.rena)
			rd_data <= mem[rd_ptr];           // Valid one cycle after rena
	end

endmodule

`default_nettype wire

// ==== src/pipe_start_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_start_fsm (
	input  wire                       CLK160,
	input  wire                       trst,
	input  wire logic                 restart,
	input  wire trig_pipe_pkg::depth_t pdepth,
	output trig_pipe_pkg::pipe_ctl_t  ctl
);

	import trig_pipe_pkg::*;

	pipe_state_e state;                   // Sequence state
	depth_t      depth_q;                 // Depth taken at restart
	depth_t      fill_cnt;                // Fill cycles already done
	logic        restart_q;               // Restart sampled at the edge
	logic        restart_d;               // Previous sample
	logic        start;                   // Rising edge of restart

	////////////////////////////////////////////////////////////
	// Restart sampling
	////////////////////////////////////////////////////////////

	// Long restart levels start the sequence only once
	assign start = restart_q & ~restart_d;

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			restart_q <= 1'b0;
			restart_d <= 1'b0;
		end else begin
			restart_q <= restart;               // Sample point
			restart_d <= restart_q;             // Edge detect
		end
	end

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK160 or posedge trst) begin
		if (trst) begin
			state    <= PS_IDLE;
			depth_q  <= '0;
			fill_cnt <= '0;
		end else if (start) begin
			state   <= PS_RESET;                // Restart from any state
			depth_q <= pdepth;                  // Latency fixed until next restart
		end else begin
			case (state)
				PS_RESET: begin
					state    <= PS_FILL;
					fill_cnt <= '0;
				end
				PS_FILL: begin
					if (fill_cnt == depth_q - depth_t'(1))
						state <= PS_RUN;            // depth_q writes done
					else
						fill_cnt <= fill_cnt + depth_t'(1);
				end
				default: state <= state;        // Idle and run hold
			endcase
		end
	end

	// Moore decode of the control set
	always_comb begin
		ctl = '0;
		case (state)
			PS_RESET: ctl.pipe_reset = 1'b1;
			PS_FILL:  ctl.wena       = 1'b1;
			PS_RUN: begin
				ctl.wena = 1'b1;
				ctl.rena = 1'b1;                  // Reads trail writes by depth_q
			end
			default:  ctl = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/trig_pipe_pkg.sv ====
`default_nettype none

package trig_pipe_pkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	localparam int DATA_W    = 32;                // One sample word
	localparam int DEPTH_W   = 9;                 // Depth, pointers, count
	localparam int BUF_WORDS = 2 ** DEPTH_W;      // Circular buffer size

	typedef logic [DATA_W-1:0]  sample_t;         // Detector sample word
	typedef logic [DEPTH_W-1:0] depth_t;          // Depth or pointer value

	////////////////////////////////////////////////////////////
	// Start sequence
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		PS_IDLE  = 2'd0,                          // Waiting for first restart
		PS_RESET = 2'd1,                          // One cycle pipeline reset
		PS_FILL  = 2'd2,                          // Writing, no reads yet
		PS_RUN   = 2'd3                           // Write and read every cycle
	} pipe_state_e;

	// Decode stage outputs, one set per segment
	typedef struct packed {
		logic pipe_reset;                         // Clear pointers and count
		logic wena;                               // Buffer write enable
		logic rena;                               // Buffer read enable
	} pipe_ctl_t;

	// Test pulse controls, shared by all segments
	typedef struct packed {
		logic sel_tpls;                           // Replace bit 0 of din
		logic inj_pulse;                          // Value put into bit 0
	} tp_ctl_t;

endpackage

`default_nettype wire
